// ==== design/bus_pkg.sv ====
`include "soc_defines.svh"

package bus_pkg;

  // Tagged address, top bit set for I/O cycles
  typedef union packed {
    struct packed {
      logic                 io_flag;
      logic [`ADDR_W-2:0]   word;
    } mem;
    struct packed {
      logic                 io_flag;
      logic [3:0]           unused;
      logic [`ADDR_W-6:0]   port;
    } io;
  } bus_addr_t;

  typedef logic [`DATA_W-1:0] bus_data_t;

  // Bit 0 low byte, bit 1 high byte
  typedef logic [1:0] byte_sel_t;

  typedef enum logic [1:0] {
    slv_gpio,
    slv_ram,
    slv_none
  } slave_sel_e;

endpackage

// ==== design/bus_switch.sv ====
`include "soc_defines.svh"

module bus_switch import bus_pkg::*, irq_pkg::*; (
  input  logic      clk,
  input  logic      sys_rst_i,

  // Master side
  input  bus_addr_t m_adr_i,
  input  logic      m_stb_i,
  output bus_data_t m_dat_o,
  output logic      m_ack_o,

  // Interrupt acknowledge
  input  logic      inta_i,
  input  irq_id_t   iid_i,

  // GPIO slave
  output logic      gpio_stb_o,
  input  bus_data_t gpio_dat_i,
  input  logic      gpio_ack_i,

  // Scratch RAM slave
  output logic      ram_stb_o,
  input  bus_data_t ram_dat_i,
  input  logic      ram_ack_i
);

  slave_sel_e slave_sel;
  logic       gpio_hit;
  logic       ram_hit;
  logic       def_stb;
  logic       def_ack;
  bus_data_t  sw_dat;

  // Port windows go through the I/O view, memory windows through the memory view
  assign gpio_hit = m_adr_i.io.io_flag &&
                    ((m_adr_i.io.port & `GPIO_MASK) == `GPIO_BASE);
  assign ram_hit  = !m_adr_i.mem.io_flag &&
                    ((m_adr_i.mem.word & `RAM_MASK) == `RAM_BASE);

  always_comb begin
    if (gpio_hit) begin
      slave_sel = slv_gpio;
    end else if (ram_hit) begin
      slave_sel = slv_ram;
    end else begin
      slave_sel = slv_none;
    end
  end

  assign gpio_stb_o = m_stb_i && (slave_sel == slv_gpio);
  assign ram_stb_o  = m_stb_i && (slave_sel == slv_ram);
  assign def_stb    = m_stb_i && (slave_sel == slv_none);

  // Default slave, same one-cycle timing as the real ones
  always_ff @(posedge clk) begin
    if (sys_rst_i) begin
      def_ack <= 1'b0;
    end else begin
      def_ack <= def_stb && !def_ack;
    end
  end

  always_comb begin
    case (slave_sel)
      slv_gpio: begin
        sw_dat  = gpio_dat_i;
        m_ack_o = gpio_ack_i;
      end
      slv_ram: begin
        sw_dat  = ram_dat_i;
        m_ack_o = ram_ack_i;
      end
      default: begin
        sw_dat  = '1;
        m_ack_o = def_ack;
      end
    endcase
  end

  // Vector read overrides the bus data during interrupt acknowledge
  assign m_dat_o = inta_i ? (`INTA_VECTOR_BASE + bus_data_t'(iid_i)) : sw_dat;

endmodule

// ==== design/gpio_regs.sv ====
`include "soc_defines.svh"

module gpio_regs import bus_pkg::*; (
  input  logic              clk,
  input  logic              sys_rst_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  bus_addr_t         adr_i,
  input  byte_sel_t         sel_i,
  input  bus_data_t         dat_i,
  output bus_data_t         dat_o,
  output logic              ack_o,
  input  logic [`SW_W-1:0]  sw_i,
  output logic [`LED_W-1:0] led_o
);

  logic [`SW_W-1:0] sw_q;
  logic             access;

  assign access = stb_i && !ack_o;

  // Switches sampled every cycle
  always_ff @(posedge clk) begin
    sw_q <= sw_i;
  end

  always_ff @(posedge clk) begin
    if (sys_rst_i) begin
      ack_o <= 1'b0;
      led_o <= '0;
    end else begin
      ack_o <= access;
      // Port word 1 holds the LEDs
      if (access && we_i && adr_i.io.port[0]) begin
        if (sel_i[0]) led_o[7:0]         <= dat_i[7:0];
        if (sel_i[1]) led_o[`LED_W-1:8]  <= dat_i[`LED_W-1:8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      dat_o <= adr_i.io.port[0] ? {{(`DATA_W-`LED_W){1'b0}}, led_o}
                                : {{(`DATA_W-`SW_W){1'b0}}, sw_q};
    end
  end

endmodule

// ==== design/interval_timer.sv ====
`include "soc_defines.svh"

module interval_timer (
  input  logic clk,
  input  logic sys_rst_i,
  output logic tick_o
);

  localparam int CNT_W = $clog2(`TIMER_PERIOD);

  logic [CNT_W-1:0] cnt;
  logic             wrap;

  assign wrap = (cnt == CNT_W'(`TIMER_PERIOD - 1));

  always_ff @(posedge clk) begin
    if (sys_rst_i) begin
      cnt    <= '0;
      tick_o <= 1'b0;
    end else begin
      cnt    <= wrap ? '0 : cnt + 1'b1;
      tick_o <= wrap;
    end
  end

endmodule

// ==== design/irq_pkg.sv ====
package irq_pkg;

  // Line 0 is the timer, higher lines are external sources
  typedef logic [7:0] irq_vec_t;

  // Index of the lowest pending line
  typedef logic [2:0] irq_id_t;

endpackage

// ==== design/reset_debounce.sv ====
`include "soc_defines.svh"

module reset_debounce (
  input  logic clk,
  input  logic rst_lck,
  output logic sys_rst_o
);

  localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

  logic [CNT_W-1:0] cnt;

  // Reload while the board reset is held, count down after release
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt       <= CNT_W'(`DEBOUNCE_CYCLES);
      sys_rst_o <= 1'b1;
    end else begin
      if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
      sys_rst_o <= (cnt != '0);
    end
  end

endmodule

// ==== design/scratch_ram.sv ====
`include "soc_defines.svh"

module scratch_ram import bus_pkg::*; (
  input  logic      clk,
  input  logic      sys_rst_i,
  input  logic      stb_i,
  input  logic      we_i,
  input  bus_addr_t adr_i,
  input  byte_sel_t sel_i,
  input  bus_data_t dat_i,
  output bus_data_t dat_o,
  output logic      ack_o
);

  bus_data_t           mem [2**`RAM_AW];
  logic [`RAM_AW-1:0]  idx;
  logic                access;

  // Only the low word bits decode, so the RAM repeats across the window
  assign idx    = adr_i.mem.word[`RAM_AW-1:0];
  assign access = stb_i && !ack_o;

  always_ff @(posedge clk) begin
    if (access) begin
      dat_o <= mem[idx];
      if (we_i && sel_i[0]) mem[idx][7:0]  <= dat_i[7:0];
      if (we_i && sel_i[1]) mem[idx][15:8] <= dat_i[15:8];
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst_i) ack_o <= 1'b0;
    else           ack_o <= access;
  end

endmodule

// ==== design/simple_pic.sv ====
module simple_pic import irq_pkg::*; (
  input  logic     clk,
  input  logic     sys_rst_i,
  input  irq_vec_t intv_i,
  input  logic     inta_i,
  output logic     intr_o,
  output irq_id_t  iid_o
);

  irq_vec_t intv_q;
  irq_vec_t pending;
  irq_vec_t clr_mask;
  logic     inta_q;
  logic     inta_rise;

  assign inta_rise = inta_i && !inta_q;
  assign clr_mask  = irq_vec_t'(inta_rise) << iid_o;

  always_ff @(posedge clk) begin
    if (sys_rst_i) begin
      intv_q  <= '0;
      inta_q  <= 1'b0;
      pending <= '0;
    end else begin
      intv_q  <= intv_i;
      inta_q  <= inta_i;
      // A fresh edge on the same line wins over the clear
      pending <= (pending & ~clr_mask) | (intv_i & ~intv_q);
    end
  end

  // Lowest pending line has priority
  always_comb begin
    iid_o = '0;
    for (int i = $bits(irq_vec_t) - 1; i >= 0; i--) begin
      if (pending[i]) iid_o = irq_id_t'(i);
    end
  end

  assign intr_o = |pending;

endmodule

// ==== design/soc_defines.svh ====
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Bus widths
`define DATA_W 16
`define ADDR_W 20

// Board I/O
`define SW_W  10
`define LED_W 14

// Reset hold after release and timer tick spacing, in clk cycles
`define DEBOUNCE_CYCLES 16
`define TIMER_PERIOD    50

// Scratch RAM word address bits
`define RAM_AW 6

// I/O ports 0xf100 - 0xf103, as 15-bit port word address
`define GPIO_BASE 15'h7880
`define GPIO_MASK 15'h7ffe

// Memory 0xc0000 - 0xcffff, as 19-bit word address
`define RAM_BASE 19'h60000
`define RAM_MASK 19'h78000

// Interrupt vector = base + id
`define INTA_VECTOR_BASE 16'h0008

`endif

// ==== design/soc_top.sv ====
`include "soc_defines.svh"

module soc_top import bus_pkg::*, irq_pkg::*; (
  input  logic              clk,
  input  logic              rst_lck,

  // External bus master
  input  bus_addr_t         m_adr_i,
  input  bus_data_t         m_dat_i,
  input  byte_sel_t         m_sel_i,
  input  logic              m_we_i,
  input  logic              m_stb_i,
  output bus_data_t         m_dat_o,
  output logic              m_ack_o,

  // Interrupts
  input  logic              inta_i,
  output logic              intr_o,
  input  logic [7:1]        irq_i,

  // Board I/O
  input  logic [`SW_W-1:0]  sw_i,
  output logic [`LED_W-1:0] led_o
);

  logic      sys_rst;
  logic      gpio_stb;
  bus_data_t gpio_dat;
  logic      gpio_ack;
  logic      ram_stb;
  bus_data_t ram_dat;
  logic      ram_ack;
  logic      timer_tick;
  irq_id_t   iid;

  reset_debounce u_rst (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .sys_rst_o (sys_rst)
  );

  bus_switch u_switch (
    .clk        (clk),
    .sys_rst_i  (sys_rst),
    .m_adr_i    (m_adr_i),
    .m_stb_i    (m_stb_i),
    .m_dat_o    (m_dat_o),
    .m_ack_o    (m_ack_o),
    .inta_i     (inta_i),
    .iid_i      (iid),
    .gpio_stb_o (gpio_stb),
    .gpio_dat_i (gpio_dat),
    .gpio_ack_i (gpio_ack),
    .ram_stb_o  (ram_stb),
    .ram_dat_i  (ram_dat),
    .ram_ack_i  (ram_ack)
  );

  gpio_regs u_gpio (
    .clk       (clk),
    .sys_rst_i (sys_rst),
    .stb_i     (gpio_stb),
    .we_i      (m_we_i),
    .adr_i     (m_adr_i),
    .sel_i     (m_sel_i),
    .dat_i     (m_dat_i),
    .dat_o     (gpio_dat),
    .ack_o     (gpio_ack),
    .sw_i      (sw_i),
    .led_o     (led_o)
  );

  scratch_ram u_ram (
    .clk       (clk),
    .sys_rst_i (sys_rst),
    .stb_i     (ram_stb),
    .we_i      (m_we_i),
    .adr_i     (m_adr_i),
    .sel_i     (m_sel_i),
    .dat_i     (m_dat_i),
    .dat_o     (ram_dat),
    .ack_o     (ram_ack)
  );

  interval_timer u_timer (
    .clk       (clk),
    .sys_rst_i (sys_rst),
    .tick_o    (timer_tick)
  );

  // Timer on line 0, external sources above it
  simple_pic u_pic (
    .clk       (clk),
    .sys_rst_i (sys_rst),
    .intv_i    ({irq_i, timer_tick}),
    .inta_i    (inta_i),
    .intr_o    (intr_o),
    .iid_o     (iid)
  );

endmodule

// ==== filelist.f ====
+incdir+design
design/bus_pkg.sv
design/irq_pkg.sv
design/reset_debounce.sv
design/bus_switch.sv
design/gpio_regs.sv
design/scratch_ram.sv
design/interval_timer.sv
design/simple_pic.sv
design/soc_top.sv
verif/soc_asserts.sv
verif/soc_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module soc_tb -f filelist.f -o Vsoc_tb
./obj_dir/Vsoc_tb 2>&1 | tee sim.log

if grep -q "All tests passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// ==== verif/soc_asserts.sv ====
module bus_switch_asserts import bus_pkg::*; (
  input logic       clk,
  input logic       sys_rst_i,
  input logic       m_stb_i,
  input logic       m_ack_o,
  input logic       gpio_stb_o,
  input logic       ram_stb_o,
  input slave_sel_e slave_sel
);

  // Ack answers the strobe seen on the cycle before
  ack_has_stb: assert property (@(posedge clk) disable iff (sys_rst_i)
    m_ack_o |-> $past(m_stb_i))
    else $error("acknowledge without a strobe on the previous cycle");

  no_double_ack: assert property (@(posedge clk) disable iff (sys_rst_i)
    m_ack_o |=> !m_ack_o)
    else $error("acknowledge high on two consecutive cycles");

  // Default slave counts as the third strobe
  one_slave_stb: assert property (@(posedge clk) disable iff (sys_rst_i)
    $onehot0({gpio_stb_o, ram_stb_o, m_stb_i && (slave_sel == slv_none)}))
    else $error("more than one slave strobe active");

endmodule

bind bus_switch bus_switch_asserts u_asserts (
  .clk        (clk),
  .sys_rst_i  (sys_rst_i),
  .m_stb_i    (m_stb_i),
  .m_ack_o    (m_ack_o),
  .gpio_stb_o (gpio_stb_o),
  .ram_stb_o  (ram_stb_o),
  .slave_sel  (slave_sel)
);

// ==== verif/soc_tb.sv ====
`include "soc_defines.svh"

module soc_tb import bus_pkg::*, irq_pkg::*; ();

  // Tests take about 330 cycles (reset and debounce, one timer period, ~115 two-cycle bus cycles)
  localparam int MAX_CYCLES = 3000;
  localparam int ACK_LIMIT  = 4;

  // Wait after rst_lck release before the first test
  localparam int SETTLE_CYCLES = 40;

  // Internal reset drops DEBOUNCE_CYCLES + 1 edges after rst_lck release
  localparam int RISE_LIMIT = `DEBOUNCE_CYCLES + 1 + `TIMER_PERIOD + 2;

  logic              clk;
  logic              rst_lck;
  bus_addr_t         m_adr_i;
  bus_data_t         m_dat_i;
  byte_sel_t         m_sel_i;
  logic              m_we_i;
  logic              m_stb_i;
  bus_data_t         m_dat_o;
  logic              m_ack_o;
  logic              inta_i;
  logic              intr_o;
  logic [7:1]        irq_i;
  logic [`SW_W-1:0]  sw_i;
  logic [`LED_W-1:0] led_o;

  // Model of the writable state
  bus_data_t ram_model [2**`RAM_AW];
  bus_data_t led_model;
  bus_data_t sw_model;

  logic [15:0] lfsr_state;
  logic        read_pending;
  bus_data_t   read_exp;
  string       read_name;
  int          checked_cnt = 0;
  int          cycle_cnt = 0;

  soc_top UUT (
    .clk     (clk),
    .rst_lck (rst_lck),
    .m_adr_i (m_adr_i),
    .m_dat_i (m_dat_i),
    .m_sel_i (m_sel_i),
    .m_we_i  (m_we_i),
    .m_stb_i (m_stb_i),
    .m_dat_o (m_dat_o),
    .m_ack_o (m_ack_o),
    .inta_i  (inta_i),
    .intr_o  (intr_o),
    .irq_i   (irq_i),
    .sw_i    (sw_i),
    .led_o   (led_o)
  );

  always #10 clk = ~clk;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compare_data(input string name, input bus_data_t exp, input bus_data_t act);
    if (act !== exp) begin
      fail_now($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic compare_id(input string name, input irq_id_t exp, input irq_id_t act);
    if (act !== exp) begin
      fail_now($sformatf("mismatch %s: expected %0d actual %0d", name, exp, act));
    end
  endtask

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_step();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ 16'hb400;
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_step()};
    end
    return r;
  endfunction

  function automatic bus_addr_t io_addr(input logic [15:0] port_byte);
    bus_addr_t a;
    a = '0;
    a.io.io_flag = 1'b1;
    a.io.port = port_byte[15:1];
    return a;
  endfunction

  function automatic bus_addr_t mem_addr(input logic [19:0] mem_byte);
    bus_addr_t a;
    a = '0;
    a.mem.word = mem_byte[19:1];
    return a;
  endfunction

  // GPIO sits at I/O bytes 0xf100 - 0xf103
  function automatic logic is_gpio(input bus_addr_t adr);
    logic [15:0] port_byte;
    port_byte = {adr.io.port, 1'b0};
    return adr.io.io_flag && port_byte >= 16'hf100 && port_byte <= 16'hf103;
  endfunction

  // RAM repeats over memory bytes 0xc0000 - 0xcffff
  function automatic logic is_ram(input bus_addr_t adr);
    logic [19:0] mem_byte;
    mem_byte = {adr.mem.word, 1'b0};
    return !adr.mem.io_flag && mem_byte >= 20'hc0000 && mem_byte <= 20'hcffff;
  endfunction

  function automatic bus_data_t merge_bytes(input bus_data_t old, input byte_sel_t sel,
                                            input bus_data_t dat);
    bus_data_t r;
    r = old;
    if (sel[0]) r[7:0] = dat[7:0];
    if (sel[1]) r[15:8] = dat[15:8];
    return r;
  endfunction

  // Expected read data, all ones where nothing decodes
  function automatic bus_data_t expected_read(input bus_addr_t adr);
    bus_data_t val;
    val = 16'hffff;
    if (is_gpio(adr)) begin
      val = adr.io.port[0] ? led_model : sw_model;
    end else if (is_ram(adr)) begin
      val = ram_model[adr.mem.word[`RAM_AW-1:0]];
    end
    return val;
  endfunction

  function automatic irq_id_t expected_id(input irq_vec_t pend);
    for (int i = 0; i < 8; i++) begin
      if (pend[i]) return irq_id_t'(i);
    end
    return '0;
  endfunction

  task automatic model_write(input bus_addr_t adr, input byte_sel_t sel, input bus_data_t dat);
    if (is_gpio(adr) && adr.io.port[0]) begin
      led_model = merge_bytes(led_model, sel, dat);
      led_model[`DATA_W-1:`LED_W] = '0;
    end else if (is_ram(adr)) begin
      ram_model[adr.mem.word[`RAM_AW-1:0]] =
        merge_bytes(ram_model[adr.mem.word[`RAM_AW-1:0]], sel, dat);
    end
  endtask

  // One bus cycle, called and returning on a falling edge
  task automatic drive_cycle(input string name, input bus_addr_t adr, input logic we,
                             input byte_sel_t sel, input bus_data_t dat);
    int waited;
    waited = 0;
    m_adr_i = adr;
    m_we_i  = we;
    m_sel_i = sel;
    m_dat_i = dat;
    m_stb_i = 1'b1;
    do begin
      @(negedge clk);
      waited++;
    end while (!m_ack_o && waited < ACK_LIMIT);
    m_stb_i = 1'b0;
    m_we_i  = 1'b0;
    if (!m_ack_o) begin
      fail_now($sformatf("%s: no acknowledge within %0d cycles of the strobe",
                         name, ACK_LIMIT));
    end else if (waited != 1) begin
      fail_now($sformatf("%s: acknowledge came %0d cycles after the strobe, not 1",
                         name, waited));
    end else begin
      // Ack still high on the next rising edge, where the data is compared
      @(negedge clk);
    end
  endtask

  task automatic write_word(input string name, input bus_addr_t adr, input byte_sel_t sel,
                            input bus_data_t dat);
    drive_cycle(name, adr, 1'b1, sel, dat);
    model_write(adr, sel, dat);
  endtask

  task automatic read_word(input string name, input bus_addr_t adr);
    int seen;
    seen = checked_cnt;
    read_name    = name;
    read_exp     = expected_read(adr);
    read_pending = 1'b1;
    drive_cycle(name, adr, 1'b0, 2'b11, '0);
    read_pending = 1'b0;
    if (checked_cnt == seen) begin
      fail_now($sformatf("%s: read data was never seen with the acknowledge", name));
    end
  endtask

  // Vector is combinational, sampled mid cycle before the pending bit clears
  task automatic inta_read(input string name, input irq_vec_t pend);
    bus_data_t vec;
    irq_id_t   exp_id;
    exp_id = expected_id(pend);
    @(negedge clk);
    inta_i = 1'b1;
    #5;
    vec = m_dat_o;
    @(negedge clk);
    inta_i = 1'b0;
    compare_id(name, exp_id, irq_id_t'(vec - `INTA_VECTOR_BASE));
    compare_data(name, `INTA_VECTOR_BASE + bus_data_t'(exp_id), vec);
  endtask

  task automatic timer_and_irq_test();
    int waited;
    // Counted from the release of rst_lck
    waited = SETTLE_CYCLES;
    while (!intr_o) begin
      if (waited >= RISE_LIMIT) begin
        fail_now("intr_o did not rise within one timer period after reset");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    inta_read("timer_vector", 8'h01);
    if (intr_o) fail_now("intr_o stayed high after the timer was acknowledged");
    irq_i[5] = 1'b1;
    irq_i[3] = 1'b1;
    inta_read("irq3_vector", 8'h28);
    inta_read("irq5_vector", 8'h20);
    if (intr_o) fail_now("intr_o stayed high after lines 3 and 5 were acknowledged");
    irq_i = '0;
  endtask

  task automatic ram_alias_test();
    logic [31:0] rnd;
    logic [19:0] wr_byte;
    logic [19:0] rd_byte;
    logic [5:0]  idx;
    byte_sel_t   sel;
    bus_data_t   dat;
    // Every word written once so partial writes start from known data
    for (int i = 0; i < 2**`RAM_AW; i++) begin
      idx = 6'(i);
      write_word("ram_fill", mem_addr({4'hc, 9'h000, idx, 1'b0}), 2'b11,
                 {2'b10, idx, 2'b01, idx});
    end
    for (int i = 0; i < 20; i++) begin
      rnd = rand_bits(15);
      wr_byte = {4'hc, rnd[14:0], 1'b0};
      rnd = rand_bits(2);
      sel = rnd[1:0];
      rnd = rand_bits(16);
      dat = rnd[15:0];
      write_word("ram_write", mem_addr(wr_byte), sel, dat);
      // Same word through another alias
      rnd = rand_bits(9);
      rd_byte = {4'hc, rnd[8:0], wr_byte[6:1], 1'b0};
      read_word($sformatf("ram_read_%0d", i), mem_addr(rd_byte));
    end
  endtask

  task automatic gpio_test();
    logic [31:0] rnd;
    bus_data_t   dat;
    rnd = rand_bits(`SW_W);
    sw_i = rnd[`SW_W-1:0];
    sw_model = bus_data_t'(sw_i);
    // Switch register needs one edge
    @(negedge clk);
    read_word("switch_read", io_addr(16'hf100));
    for (int s = 0; s < 4; s++) begin
      rnd = rand_bits(16);
      dat = rnd[15:0];
      write_word("led_write", io_addr(16'hf102), byte_sel_t'(s), dat);
      compare_data($sformatf("led_sel_%0d", s), led_model, bus_data_t'(led_o));
      read_word($sformatf("led_read_%0d", s), io_addr(16'hf102));
    end
  endtask

  // Compare process
  always @(posedge clk) begin
    if (read_pending && m_ack_o) begin
      checked_cnt++;
      compare_data(read_name, read_exp, m_dat_o);
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      fail_now("run reached the cycle limit before the tests finished");
    end
  end

  initial begin
    clk          = 1'b0;
    rst_lck      = 1'b0;
    m_adr_i      = '0;
    m_dat_i      = '0;
    m_sel_i      = '0;
    m_we_i       = 1'b0;
    m_stb_i      = 1'b0;
    inta_i       = 1'b0;
    irq_i        = '0;
    sw_i         = '0;
    lfsr_state   = 16'd19;
    led_model    = '0;
    sw_model     = '0;
    read_pending = 1'b0;
    read_exp     = '0;
    read_name    = "";
    repeat (10) @(negedge clk);
    if (m_ack_o || intr_o) fail_now("m_ack_o or intr_o was high during reset");
    rst_lck = 1'b1;
    // Debounce hold
    repeat (SETTLE_CYCLES) @(negedge clk);
    timer_and_irq_test();
    ram_alias_test();
    gpio_test();
    read_word("unmapped_mem", mem_addr(20'h10000));
    read_word("unmapped_io", io_addr(16'hf104));
    $display("All tests passed");
    $finish;
  end

endmodule
